// File: include/translator_settings.svh
/*
 * Avalon master translator widths
 * Word-side widths of the master port, byte-side widths of the
 * universal port and the word-to-byte shift between them.
 */

`ifndef TRANSLATOR_SETTINGS_SVH
`define TRANSLATOR_SETTINGS_SVH

// word-addressed master side
`define AV_ADDRESS_W         30
`define AV_DATA_W            32
`define AV_BYTEENABLE_W      4
`define AV_BURSTCOUNT_W      4

// byte-addressed universal side
`define BYTES_PER_WORD_LOG2  2
`define UAV_ADDRESS_W        32
`define UAV_BURSTCOUNT_W     6

`endif

// File: run.sh
#!/bin/sh
# Verilator build and run of the master translator testbench
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

top=translator_tb
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert \
   -f src.f \
   --top-module "$top" \
   --Mdir "$build_dir" \
   -o "$top"
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit $status
fi

"./$build_dir/$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi

if grep -q "ALL TESTS PASSED" "$log"; then
   echo "result: pass"
   exit 0
else
   echo "result: fail"
   exit 1
fi

// File: source/beat_if.sv
/*
 * Per-beat control bundle
 * Requests and stall from the top level, transfer strobes from the
 * tracker and the last-beat flag from the sequencer.
 */

`timescale 1ns/1ps

interface beat_if;

   // master requests and slave stall
   logic write;
   logic read;
   logic waitrequest;

   // strobes for the universal port
   logic begin_transfer;
   logic begin_burst;

   // remaining count of the current beat is one
   logic last_beat;

   modport tracker (
      input  write, read, waitrequest, last_beat,
      output begin_transfer, begin_burst
   );

   modport sequencer (
      input  write, waitrequest, begin_burst,
      output last_beat
   );

endinterface

// File: source/burst_sequencer.sv
/*
 * Burst sequencer
 * Turns word address and word burst count into byte units and,
 * through a write burst, hands each beat its own byte address and
 * remaining byte count.
 */

`timescale 1ns/1ps

`include "translator_settings.svh"

module burst_sequencer (
   input  logic                      clk,
   input  logic                      reset,
   input  translator_pkg::word_addr_t  av_address,
   input  translator_pkg::word_count_t av_burstcount,
   beat_if.sequencer                 beat,
   output translator_pkg::byte_addr_t  uav_address,
   output translator_pkg::byte_count_t uav_burstcount
);

   import translator_pkg::*;

   // address step from one beat to the next
   localparam byte_addr_t word_bytes = byte_addr_t'(1) << `BYTES_PER_WORD_LOG2;

   byte_addr_t  first_address;
   byte_addr_t  address_reg;
   byte_addr_t  beat_address;
   word_count_t words_reg;
   word_count_t beat_words;
   logic        write_accepted;

   // ----------------------------------------------------------
   // word to byte conversion
   // ----------------------------------------------------------

   assign first_address = byte_addr_t'(av_address) << `BYTES_PER_WORD_LOG2;

   // ----------------------------------------------------------
   // per-beat selection
   // ----------------------------------------------------------

   // first beat of a burst, and every read, come straight from the master
   always_comb begin
      if (beat.begin_burst) begin
         beat_address = first_address;
         beat_words   = av_burstcount;
      end else begin
         beat_address = address_reg;
         beat_words   = words_reg;
      end
   end

   assign uav_address    = beat_address;
   assign uav_burstcount = byte_count_t'(beat_words) << `BYTES_PER_WORD_LOG2;
   assign beat.last_beat = (beat_words == word_count_t'(1));

   // ----------------------------------------------------------
   // next beat registers
   // ----------------------------------------------------------

   assign write_accepted = beat.write & ~beat.waitrequest;

   // advanced only when the slave takes a write beat
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         address_reg <= '0;
         words_reg   <= '0;
      end else if (write_accepted) begin
         address_reg <= beat_address + word_bytes;
         words_reg   <= beat_words - word_count_t'(1);
      end
   end

endmodule

// File: source/master_translator.sv
/*
 * Avalon-MM master translator
 * Word-addressed Avalon master in, byte-addressed universal master
 * out. Write bursts get a fresh address and remaining count on every
 * beat; data, byte enables, read data and stall pass through.
 */

`timescale 1ns/1ps

module master_translator (
   input  logic                        clk,
   input  logic                        reset,

   // Avalon master side
   input  logic                        av_write,
   input  logic                        av_read,
   input  translator_pkg::word_addr_t  av_address,
   input  translator_pkg::word_count_t av_burstcount,
   input  translator_pkg::byte_en_t    av_byteenable,
   input  translator_pkg::data_t       av_writedata,
   output translator_pkg::data_t       av_readdata,
   output logic                        av_readdatavalid,
   output logic                        av_waitrequest,

   // universal side
   output logic                        uav_write,
   output logic                        uav_read,
   output translator_pkg::byte_addr_t  uav_address,
   output translator_pkg::byte_count_t uav_burstcount,
   output translator_pkg::byte_en_t    uav_byteenable,
   output translator_pkg::data_t       uav_writedata,
   output logic                        uav_begintransfer,
   output logic                        uav_beginbursttransfer,
   input  translator_pkg::data_t       uav_readdata,
   input  logic                        uav_readdatavalid,
   input  logic                        uav_waitrequest
);

   beat_if beat ();

   // ----------------------------------------------------------
   // control into the beat bundle
   // ----------------------------------------------------------

   assign beat.write       = av_write;
   assign beat.read        = av_read;
   assign beat.waitrequest = uav_waitrequest;

   transfer_tracker transfer_tracker_inst (
      .clk   (clk),
      .reset (reset),
      .beat  (beat.tracker)
   );

   burst_sequencer burst_sequencer_inst (
      .clk            (clk),
      .reset          (reset),
      .av_address     (av_address),
      .av_burstcount  (av_burstcount),
      .beat           (beat.sequencer),
      .uav_address    (uav_address),
      .uav_burstcount (uav_burstcount)
   );

   assign uav_begintransfer      = beat.begin_transfer;
   assign uav_beginbursttransfer = beat.begin_burst;

   // ----------------------------------------------------------
   // pass-through
   // ----------------------------------------------------------

   // requests and write payload
   assign uav_write      = av_write;
   assign uav_read       = av_read;
   assign uav_byteenable = av_byteenable;
   assign uav_writedata  = av_writedata;

   // read return and stall in the same cycle
   assign av_readdata      = uav_readdata;
   assign av_readdatavalid = uav_readdatavalid;
   assign av_waitrequest   = uav_waitrequest;

endmodule

// File: source/transfer_tracker.sv
/*
 * Transfer tracker
 * Generates begintransfer and beginbursttransfer for the universal
 * port and follows whether a write burst is in progress.
 */

`timescale 1ns/1ps

module transfer_tracker (
   input logic     clk,
   input logic     reset,
   beat_if.tracker beat
);

   import translator_pkg::*;

   logic         request;
   logic         write_accepted;
   logic         stalled;
   burst_state_t state;
   burst_state_t state_next;

   assign request        = beat.write | beat.read;
   assign write_accepted = beat.write & ~beat.waitrequest;

   // ----------------------------------------------------------
   // begintransfer
   // ----------------------------------------------------------

   // high from the first stalled cycle of a beat until it is taken
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stalled <= 1'b0;
      end else if (request && beat.waitrequest) begin
         stalled <= 1'b1;
      end else if (!beat.waitrequest) begin
         stalled <= 1'b0;
      end
   end

   assign beat.begin_transfer = request & ~stalled;

   // ----------------------------------------------------------
   // burst state
   // ----------------------------------------------------------

   always_comb begin
      state_next = state;
      case (state)
         BURST_IDLE: begin
            // single-beat writes never leave idle
            if (write_accepted && !beat.last_beat) begin
               state_next = BURST_MID;
            end
         end
         BURST_MID: begin
            if (beat.read || (write_accepted && beat.last_beat)) begin
               state_next = BURST_IDLE;
            end
         end
         default: begin
            state_next = BURST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= BURST_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // a read is always a complete burst in one command
   assign beat.begin_burst = (request & (state == BURST_IDLE)) | beat.read;

endmodule

// File: source/translator_pkg.sv
/*
 * Avalon master translator types
 * Vector types for addresses, counts and data on both sides of
 * the translator, and the burst tracking state.
 */

`include "translator_settings.svh"

package translator_pkg;

   // master side
   typedef logic [`AV_ADDRESS_W-1:0]     word_addr_t;
   typedef logic [`AV_BURSTCOUNT_W-1:0]  word_count_t;

   // universal side
   typedef logic [`UAV_ADDRESS_W-1:0]    byte_addr_t;
   typedef logic [`UAV_BURSTCOUNT_W-1:0] byte_count_t;

   // payload shared by both sides
   typedef logic [`AV_DATA_W-1:0]        data_t;
   typedef logic [`AV_BYTEENABLE_W-1:0]  byte_en_t;

   // write burst progress
   typedef enum logic {
      BURST_IDLE,
      BURST_MID
   } burst_state_t;

endpackage

// File: src.f
+incdir+include
source/translator_pkg.sv
source/beat_if.sv
source/transfer_tracker.sv
source/burst_sequencer.sv
source/master_translator.sv
verif/translator_tb.sv

// File: include/translator_tb_vectors.svh
/*
 * Testbench transaction table
 * One entry per transaction: kind, word address, burst length in
 * words and the waitrequest cycles of each beat, one nibble per beat
 * with beat 0 in the low nibble. A read uses only the low nibble.
 */

`ifndef TRANSLATOR_TB_VECTORS_SVH
`define TRANSLATOR_TB_VECTORS_SVH

typedef struct packed {
   logic                        is_read;
   logic [`AV_ADDRESS_W-1:0]    address;
   logic [`AV_BURSTCOUNT_W-1:0] length;
   logic [31:0]                 waits;
} txn_t;

localparam int num_txns = 12;

// kind, word address, words, wait cycles per beat
localparam txn_t txn_table [num_txns] = '{
   // back-to-back writes without stalls
   '{1'b0, 30'h0000_0010, 4'd4, 32'h0000_0000},
   '{1'b0, 30'h0000_0100, 4'd4, 32'h0000_0000},
   '{1'b0, 30'h0000_0200, 4'd1, 32'h0000_0000},
   '{1'b1, 30'h0000_0400, 4'd4, 32'h0000_0000},
   // stalls on several beats of a full burst
   '{1'b0, 30'h0001_2345, 4'd8, 32'h1020_0301},
   '{1'b0, 30'h0001_2400, 4'd3, 32'h0000_0222},
   '{1'b1, 30'h0002_0000, 4'd8, 32'h0000_0003},
   // top of the byte address space
   '{1'b0, 30'h3FFF_FFF8, 4'd8, 32'h0000_0000},
   '{1'b1, 30'h0000_0004, 4'd1, 32'h0000_0001},
   '{1'b0, 30'h0000_0800, 4'd2, 32'h0000_0010},
   '{1'b0, 30'h0000_0900, 4'd1, 32'h0000_0002},
   '{1'b0, 30'h0000_0A00, 4'd5, 32'h0004_0000}
};

`endif

// File: verif/translator_tb.sv
/*
 * Testbench for the Avalon-MM master translator
 * Applies a table of read and write bursts with per-beat stalls,
 * models the slave's waitrequest and read return, and checks the
 * byte-side commands and strobes cycle by cycle.
 */

`timescale 1ns/1ps

`include "translator_settings.svh"

module translator_tb;

   import translator_pkg::*;

   `include "translator_tb_vectors.svh"

   logic        clk;
   logic        reset;
   logic        av_write;
   logic        av_read;
   word_addr_t  av_address;
   word_count_t av_burstcount;
   byte_en_t    av_byteenable;
   data_t       av_writedata;
   data_t       av_readdata;
   logic        av_readdatavalid;
   logic        av_waitrequest;
   logic        uav_write;
   logic        uav_read;
   byte_addr_t  uav_address;
   byte_count_t uav_burstcount;
   byte_en_t    uav_byteenable;
   data_t       uav_writedata;
   logic        uav_begintransfer;
   logic        uav_beginbursttransfer;
   data_t       uav_readdata;
   logic        uav_readdatavalid;
   logic        uav_waitrequest;

   int error_count = 0;
   int check_count = 0;
   int cycle_count = 0;

   master_translator master_translator_inst (
      .clk                    (clk),
      .reset                  (reset),
      .av_write               (av_write),
      .av_read                (av_read),
      .av_address             (av_address),
      .av_burstcount          (av_burstcount),
      .av_byteenable          (av_byteenable),
      .av_writedata           (av_writedata),
      .av_readdata            (av_readdata),
      .av_readdatavalid       (av_readdatavalid),
      .av_waitrequest         (av_waitrequest),
      .uav_write              (uav_write),
      .uav_read               (uav_read),
      .uav_address            (uav_address),
      .uav_burstcount         (uav_burstcount),
      .uav_byteenable         (uav_byteenable),
      .uav_writedata          (uav_writedata),
      .uav_begintransfer      (uav_begintransfer),
      .uav_beginbursttransfer (uav_beginbursttransfer),
      .uav_readdata           (uav_readdata),
      .uav_readdatavalid      (uav_readdatavalid),
      .uav_waitrequest        (uav_waitrequest)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // ----------------------------------------------------------
   // helpers
   // ----------------------------------------------------------

   // reset, every beat with its stalls, read returns and a margin
   function automatic int cycle_limit();
      int total;
      int i;
      int k;
      total = 5 + 20;
      for (i = 0; i < num_txns; i++) begin
         if (txn_table[i].is_read) begin
            total += int'(txn_table[i].waits[3:0]) + 1 + int'(txn_table[i].length);
         end else begin
            for (k = 0; k < int'(txn_table[i].length); k++) begin
               total += int'(txn_table[i].waits[4*k +: 4]) + 1;
            end
         end
      end
      return total;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      check_count++;
      assert (got === expected) else begin
         error_count++;
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
      end
   endtask

   // master and slave inputs for one cycle
   task automatic drive_inputs(
      input logic        write,
      input logic        read,
      input word_addr_t  address,
      input word_count_t length,
      input data_t       wr_data,
      input byte_en_t    wr_be,
      input logic        stall,
      input logic        rd_valid,
      input data_t       rd_data
   );
      av_write          <= write;
      av_read           <= read;
      av_address        <= address;
      av_burstcount     <= length;
      av_writedata      <= wr_data;
      av_byteenable     <= wr_be;
      uav_waitrequest   <= stall;
      uav_readdatavalid <= rd_valid;
      uav_readdata      <= rd_data;
   endtask

   task automatic check_idle();
      @(posedge clk);
      drive_inputs(1'b0, 1'b0, '0, '0, '0, '0, 1'b0, 1'b0, '0);
      @(negedge clk);
      check_value("uav_begintransfer", 32'(uav_begintransfer), 32'd0);
      check_value("uav_beginbursttransfer", 32'(uav_beginbursttransfer), 32'd0);
      check_value("av_readdatavalid", 32'(av_readdatavalid), 32'd0);
   endtask

   task automatic run_write(input txn_t txn);
      byte_addr_t  exp_address;
      byte_count_t exp_count;
      data_t       data;
      byte_en_t    be;
      int          stall_left;
      int          k;
      logic        stall;
      logic        accepted;
      logic        first_cycle;
      for (k = 0; k < int'(txn.length); k++) begin
         data        = $urandom;
         be          = byte_en_t'($urandom);
         stall_left  = int'(txn.waits[4*k +: 4]);
         exp_address = byte_addr_t'(txn.address) * 4 + byte_addr_t'(4 * k);
         exp_count   = byte_count_t'(4 * (int'(txn.length) - k));
         accepted    = 1'b0;
         first_cycle = 1'b1;
         // the request is held until the slave drops waitrequest
         while (!accepted) begin
            stall = (stall_left != 0);
            @(posedge clk);
            drive_inputs(1'b1, 1'b0, txn.address, txn.length, data, be,
                         stall, 1'b0, '0);
            @(negedge clk);
            check_value("uav_write", 32'(uav_write), 32'd1);
            check_value("uav_read", 32'(uav_read), 32'd0);
            check_value("uav_address", uav_address, exp_address);
            check_value("uav_burstcount", 32'(uav_burstcount), 32'(exp_count));
            check_value("uav_beginbursttransfer", 32'(uav_beginbursttransfer), 32'(k == 0));
            check_value("uav_begintransfer", 32'(uav_begintransfer), 32'(first_cycle));
            check_value("uav_writedata", uav_writedata, data);
            check_value("uav_byteenable", 32'(uav_byteenable), 32'(be));
            check_value("av_waitrequest", 32'(av_waitrequest), 32'(stall));
            if (!stall) begin
               accepted = 1'b1;
            end else begin
               stall_left--;
            end
            first_cycle = 1'b0;
         end
      end
   endtask

   // one read-valid beat from the slave per word of the burst
   task automatic return_read_data(input word_count_t length);
      data_t data;
      int    k;
      for (k = 0; k < int'(length); k++) begin
         data = $urandom;
         @(posedge clk);
         drive_inputs(1'b0, 1'b0, '0, '0, '0, '0, 1'b0, 1'b1, data);
         @(negedge clk);
         check_value("av_readdatavalid", 32'(av_readdatavalid), 32'd1);
         check_value("av_readdata", av_readdata, data);
         check_value("uav_begintransfer", 32'(uav_begintransfer), 32'd0);
         check_value("uav_beginbursttransfer", 32'(uav_beginbursttransfer), 32'd0);
      end
   endtask

   task automatic run_read(input txn_t txn);
      int   stall_left;
      logic stall;
      logic accepted;
      logic first_cycle;
      stall_left  = int'(txn.waits[3:0]);
      accepted    = 1'b0;
      first_cycle = 1'b1;
      while (!accepted) begin
         stall = (stall_left != 0);
         @(posedge clk);
         drive_inputs(1'b0, 1'b1, txn.address, txn.length, '0, '0,
                      stall, 1'b0, '0);
         @(negedge clk);
         check_value("uav_read", 32'(uav_read), 32'd1);
         check_value("uav_write", 32'(uav_write), 32'd0);
         check_value("uav_address", uav_address, byte_addr_t'(txn.address) * 4);
         check_value("uav_burstcount", 32'(uav_burstcount), 32'(4 * int'(txn.length)));
         check_value("uav_beginbursttransfer", 32'(uav_beginbursttransfer), 32'd1);
         check_value("uav_begintransfer", 32'(uav_begintransfer), 32'(first_cycle));
         check_value("av_waitrequest", 32'(av_waitrequest), 32'(stall));
         if (!stall) begin
            accepted = 1'b1;
         end else begin
            stall_left--;
         end
         first_cycle = 1'b0;
      end
      return_read_data(txn.length);
   endtask

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------

   initial begin
      int i;
      void'($urandom(69));
      reset <= 1'b1;
      drive_inputs(1'b0, 1'b0, '0, '0, '0, '0, 1'b0, 1'b0, '0);
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      check_idle();
      for (i = 0; i < num_txns; i++) begin
         if (txn_table[i].is_read) begin
            run_read(txn_table[i]);
         end else begin
            run_write(txn_table[i]);
         end
      end
      check_idle();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= cycle_limit()) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit());
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

endmodule
